/* rtl/ctn_bus_pkg.sv */
/* CTN port bus definitions
   Request and response structs, data word views and bus widths */

package ctn_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  parameter int AddrWidth = 32;  // Byte address
  parameter int DataWidth = 32;
  parameter int NumBytes  = DataWidth / 8;  // Byte lanes per word

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // One data word seen whole or as byte lanes
  typedef union packed {
    logic [DataWidth-1:0]     word;
    logic [NumBytes-1:0][7:0] bytes;
  } ctn_word_u;

  // Host request with no grant, up to one per cycle
  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [AddrWidth-1:0] addr;   // Byte address
    ctn_word_u            wdata;
    logic [NumBytes-1:0]  be;     // Byte enables
  } ctn_req_t;

  // Response returned a fixed number of cycles after the request
  typedef struct packed {
    logic      valid;
    logic      error;
    ctn_word_u rdata;  // Zero on writes and errors
  } ctn_rsp_t;

endpackage

/* rtl/ctn_map_pkg.sv */
/* CTN port address map and timing
   RAM window base, response latency and power-on supply thresholds */

package ctn_map_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////

  // Must be aligned to the window size
  parameter logic [31:0] RamBase = 32'h0010_0000;

  // Request to response in clk_aon cycles
  parameter int RamLatency = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Emulated supply
  ////////////////////////////////////////////////////////////////////////////

  parameter int PorCountWidth = 4;
  parameter int PorCountMax   = 15;  // Counter saturates here

  // Low below the first, high up to the second, low again up to the third
  parameter int SupplyLowEnd    = 4;
  parameter int SupplyHighEnd   = 8;
  parameter int SupplyGlitchEnd = 12;

endpackage

/* rtl/ctn_por_emu.sv */
/* Emulated power-on supply
   Saturating counter decoded into a low-high-low-high supply, registered as power-good */

`timescale 1ns/1ps

module ctn_por_emu (
  input  logic clk_aon,
  input  logic rst_n_i,
  output logic pok_o
);

  import ctn_map_pkg::*;

  logic [PorCountWidth-1:0] cnt_q;
  logic                     supply;
  logic                     pok_q;

  // Count up once per edge until saturation
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_q < PorCountWidth'(PorCountMax)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Fake supply pattern with one dropout
  always_comb begin
    if (cnt_q < PorCountWidth'(SupplyLowEnd)) begin
      supply = 1'b0;               // Ramping up
    end else if (cnt_q < PorCountWidth'(SupplyHighEnd)) begin
      supply = 1'b1;               // First good window
    end else if (cnt_q < PorCountWidth'(SupplyGlitchEnd)) begin
      supply = 1'b0;               // Dropout
    end else begin
      supply = 1'b1;               // Stable from here on
    end
  end

  // Power-good lags the count by one edge
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pok_q <= 1'b0;
    end else begin
      pok_q <= supply;
    end
  end

  assign pok_o = pok_q;

endmodule

/* rtl/ctn_steer.sv */
/* CTN request steering
   Window decode, error response pipeline and merge with RAM responses */

`timescale 1ns/1ps

module ctn_steer #(
  parameter int RamDepth = 1024
) (
  input  logic                 clk_aon,
  input  logic                 rst_n_i,
  input  ctn_bus_pkg::ctn_req_t req_i,
  input  logic                 pok_i,
  output ctn_bus_pkg::ctn_req_t ram_req_o,
  input  ctn_bus_pkg::ctn_rsp_t ram_rsp_i,
  output ctn_bus_pkg::ctn_rsp_t rsp_o
);

  import ctn_bus_pkg::*;
  import ctn_map_pkg::*;

  localparam int WinBytes = RamDepth * NumBytes;
  localparam logic [AddrWidth-1:0] WinMask = ~(AddrWidth'(WinBytes - 1));

  logic                  in_win;
  logic                  fwd;
  logic                  err_push;
  logic [RamLatency-1:0] err_q;  // One marker per rejected request

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  assign in_win   = (req_i.addr & WinMask) == RamBase;
  assign fwd      = req_i.valid & in_win & pok_i;
  assign err_push = req_i.valid & ~fwd;  // Out of window or not powered

  // Only forwarded requests reach the adapter
  always_comb begin
    ram_req_o       = req_i;
    ram_req_o.valid = fwd;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error pipeline
  ////////////////////////////////////////////////////////////////////////////

  // Same depth as the RAM path so the two never line up on one cycle
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= '0;
    end else begin
      err_q <= {err_q[RamLatency-2:0], err_push};
    end
  end

  // Merge
  always_comb begin
    if (err_q[RamLatency-1]) begin
      rsp_o       = '0;
      rsp_o.valid = 1'b1;
      rsp_o.error = 1'b1;   // rdata stays zero
    end else begin
      rsp_o = ram_rsp_i;
    end
  end

endmodule

/* rtl/ctn_sram_adapter.sv */
/* Bus to RAM adapter
   Turns requests into RAM cycles and builds responses from read data or write acks */

`timescale 1ns/1ps

module ctn_sram_adapter #(
  parameter int RamDepth = 1024
) (
  input  logic                          clk_aon,
  input  logic                          rst_n_i,
  input  ctn_bus_pkg::ctn_req_t         req_i,
  output ctn_bus_pkg::ctn_rsp_t         rsp_o,
  // RAM side
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [$clog2(RamDepth)-1:0]   mem_addr_o,
  output ctn_bus_pkg::ctn_word_u        mem_wdata_o,
  output ctn_bus_pkg::ctn_word_u        mem_wmask_o,
  input  ctn_bus_pkg::ctn_word_u        mem_rdata_i,
  input  logic                          mem_rvalid_i
);

  import ctn_bus_pkg::*;
  import ctn_map_pkg::*;

  localparam int WordAw  = $clog2(RamDepth);
  localparam int ByteOff = $clog2(NumBytes);  // Byte offset bits within a word

  logic [RamLatency-1:0] wack_q;
  logic                  wack;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  assign mem_req_o   = req_i.valid;
  assign mem_we_o    = req_i.we;
  assign mem_wdata_o = req_i.wdata;

  // Word index inside the window with the base bits dropped
  assign mem_addr_o = req_i.addr[ByteOff +: WordAw];

  // Each byte enable covers one lane of the bit mask
  always_comb begin
    mem_wmask_o = '0;
    for (int b = 0; b < NumBytes; b++) begin
      mem_wmask_o.bytes[b] = {8{req_i.be[b]}};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  // Write flags walk alongside the RAM stages
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wack_q <= '0;
    end else begin
      wack_q <= {wack_q[RamLatency-2:0], req_i.valid & req_i.we};
    end
  end

  assign wack = wack_q[RamLatency-1];

  always_comb begin
    rsp_o       = '0;
    rsp_o.valid = mem_rvalid_i | wack;
    rsp_o.error = 1'b0;              // RAM itself never fails
    if (mem_rvalid_i) begin
      rsp_o.rdata = mem_rdata_i;
    end
  end

endmodule

/* rtl/ctn_ram_1p.sv */
/* Single-port RAM
   Registered input stage, bit-masked array write and registered read output */

`timescale 1ns/1ps

module ctn_ram_1p #(
  parameter int RamDepth = 1024
) (
  input  logic                        clk_aon,
  input  logic                        rst_n_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(RamDepth)-1:0] addr_i,
  input  ctn_bus_pkg::ctn_word_u      wdata_i,
  input  ctn_bus_pkg::ctn_word_u      wmask_i,
  output ctn_bus_pkg::ctn_word_u      rdata_o,
  output logic                        rvalid_o
);

  import ctn_bus_pkg::*;

  localparam int WordAw = $clog2(RamDepth);

  logic [DataWidth-1:0] mem [RamDepth];

  // Input stage
  logic              req_q, we_q;
  logic [WordAw-1:0] addr_q;
  ctn_word_u         wdata_q, wmask_q;

  // Array read port and output stage
  logic      rd_valid_q, rvalid_q;
  ctn_word_u rd_data_q, rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q      <= 1'b0;
      we_q       <= 1'b0;
      rd_valid_q <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      req_q      <= req_i;
      we_q       <= we_i;
      rd_valid_q <= req_q & ~we_q;  // Reads only
      rvalid_q   <= rd_valid_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon) begin
    addr_q  <= addr_i;
    wdata_q <= wdata_i;
    wmask_q <= wmask_i;
    if (req_q && we_q) begin
      // Unmasked bits keep their old value
      mem[addr_q] <= (mem[addr_q] & ~wmask_q.word) | (wdata_q.word & wmask_q.word);
    end
    if (req_q && !we_q) begin
      rd_data_q.word <= mem[addr_q];
    end
    rdata_q <= rd_data_q;
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

/* rtl/ctn_port_top.sv */
/* CTN memory port top
   Supply emulation, window steering, bus adapter and RAM on the always-on clock */

`timescale 1ns/1ps

module ctn_port_top #(
  parameter int RamDepth = 1024
) (
  input  logic                  clk_aon,
  input  logic                  rst_n_i,
  input  ctn_bus_pkg::ctn_req_t req_i,
  output ctn_bus_pkg::ctn_rsp_t rsp_o,
  output logic                  pok_o
);

  import ctn_bus_pkg::*;

  localparam int WordAw = $clog2(RamDepth);

  logic     pok;
  ctn_req_t sram_req;   // Steered request into the adapter
  ctn_rsp_t sram_rsp;

  // Plain RAM port
  logic              mem_req, mem_we, mem_rvalid;
  logic [WordAw-1:0] mem_addr;
  ctn_word_u         mem_wdata, mem_wmask, mem_rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Supply and steering
  ////////////////////////////////////////////////////////////////////////////

  ctn_por_emu u_por_emu (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n_i),
    .pok_o   (pok)
  );

  assign pok_o = pok;

  ctn_steer #(
    .RamDepth (RamDepth)
  ) u_steer (
    .clk_aon   (clk_aon),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .pok_i     (pok),
    .ram_req_o (sram_req),
    .ram_rsp_i (sram_rsp),
    .rsp_o     (rsp_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Adapter and RAM
  ////////////////////////////////////////////////////////////////////////////

  ctn_sram_adapter #(
    .RamDepth (RamDepth)
  ) u_sram_adapter (
    .clk_aon      (clk_aon),
    .rst_n_i      (rst_n_i),
    .req_i        (sram_req),
    .rsp_o        (sram_rsp),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_wmask_o  (mem_wmask),
    .mem_rdata_i  (mem_rdata),
    .mem_rvalid_i (mem_rvalid)
  );

  ctn_ram_1p #(
    .RamDepth (RamDepth)
  ) u_ram (
    .clk_aon  (clk_aon),
    .rst_n_i  (rst_n_i),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .wmask_i  (mem_wmask),
    .rdata_o  (mem_rdata),
    .rvalid_o (mem_rvalid)
  );

endmodule

/* bench/tb_clk_gen.sv */
/* Testbench clock and reset
   Free running clk_aon and an active low reset held for a few cycles */

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PeriodNs  = 40,
  parameter int RstCycles = 3
) (
  output logic clk_aon,
  output logic rst_n_o
);

  initial begin
    clk_aon = 1'b0;
    forever #(PeriodNs / 2) clk_aon = ~clk_aon;
  end

  // Release on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RstCycles) @(posedge clk_aon);
    rst_n_o <= 1'b1;
  end

endmodule

/* bench/tb_ctn_port.sv */
/* CTN memory port testbench
   Drives host requests, models the RAM and checks every response and the supply level */

`timescale 1ns/1ps

module tb_ctn_port;

  import ctn_bus_pkg::*;
  import ctn_map_pkg::*;

  localparam int RamDepth  = 1024;
  localparam int PeriodNs  = 40;
  localparam int RstCycles = 3;
  localparam int NumTests  = 6;
  localparam int FillWords = 64;   // Words with known content for random traffic
  localparam int NumRandom = 500;
  localparam logic [31:0] WinBytes = 32'(RamDepth * NumBytes);
  localparam logic [31:0] WinEnd   = RamBase + WinBytes;  // First byte above the window

  // Sum of all test lengths in cycles plus a margin
  localparam int TestCycles = RstCycles + 24 + 2 * FillWords + 30 + 20 + NumRandom + 6 * 8;
  localparam int TimeoutNs  = (TestCycles + 200) * PeriodNs;

  // Expected response tagged with its test
  typedef struct packed {
    ctn_rsp_t   rsp;
    logic [2:0] tid;
  } exp_t;

  logic      clk_aon;
  logic      rst_n;
  ctn_req_t  req;
  ctn_rsp_t  rsp;
  logic      pok;
  logic [2:0] cur_tid;
  int        cyc_idx;
  int        checks [NumTests];
  int        fails  [NumTests];
  exp_t      exp_q [$];
  ctn_word_u model_mem [int];   // Reference RAM by word index

  tb_clk_gen #(
    .PeriodNs  (PeriodNs),
    .RstCycles (RstCycles)
  ) u_clk_gen (
    .clk_aon (clk_aon),
    .rst_n_o (rst_n)
  );

  ctn_port_top #(
    .RamDepth (RamDepth)
  ) ctn_port_top_i (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n),
    .req_i   (req),
    .rsp_o   (rsp),
    .pok_o   (pok)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  // Power-good after k edges out of reset
  function automatic logic expected_pok(int k);
    int cnt;
    if (k == 0) return 1'b0;
    cnt = (k - 1 > PorCountMax) ? PorCountMax : k - 1;
    return (cnt >= SupplyLowEnd && cnt < SupplyHighEnd) || cnt >= SupplyGlitchEnd;
  endfunction

  function automatic logic in_window(logic [31:0] addr);
    return addr >= RamBase && addr < WinEnd;
  endfunction

  function automatic int word_index(logic [31:0] addr);
    return int'((addr - RamBase) >> 2);
  endfunction

  // Enabled lanes take the new bytes
  function automatic ctn_word_u merge_bytes(ctn_word_u old_w, ctn_word_u new_w,
                                            logic [NumBytes-1:0] be);
    ctn_word_u res;
    res = old_w;
    for (int b = 0; b < NumBytes; b++) begin
      if (be[b]) res.bytes[b] = new_w.bytes[b];
    end
    return res;
  endfunction

  function automatic logic [31:0] fill_value(logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
  endfunction

  function automatic string test_name(int id);
    case (id)
      0:       return "supply";
      1:       return "reject_before_pok";
      2:       return "write_then_read";
      3:       return "partial_writes";
      4:       return "outside_window";
      default: return "random_stream";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checker sampling mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_aon) begin : check_blk
    exp_t e;
    exp_t nxt;
    logic pok_exp;
    int   widx;
    if (rst_n) begin
      cyc_idx++;
      pok_exp = expected_pok(cyc_idx - 1);
      checks[0]++;
      assert (pok === pok_exp) else begin
        fails[0]++;
        $display("CHECK FAILED supply: cycle %0d pok_o expected %b actual %b",
                 cyc_idx, pok_exp, pok);
      end
      // Response due for the request three cycles back
      if (exp_q.size() >= RamLatency) begin
        e = exp_q.pop_front();
        if (e.rsp.valid) begin
          checks[e.tid]++;
          assert (rsp === e.rsp) else begin
            fails[e.tid]++;
            $display("CHECK FAILED %s: expected valid=%b error=%b rdata=%h,",
                     test_name(e.tid), e.rsp.valid, e.rsp.error, e.rsp.rdata.word,
                     " actual valid=%b error=%b rdata=%h",
                     rsp.valid, rsp.error, rsp.rdata.word);
          end
        end else begin
          assert (rsp.valid === 1'b0) else begin
            fails[e.tid]++;
            $display("%s: response seen with no request three cycles earlier",
                     test_name(e.tid));
          end
        end
      end
      nxt = '0;
      nxt.tid = cur_tid;
      if (req.valid) begin
        nxt.rsp.valid = 1'b1;
        if (in_window(req.addr) && pok_exp) begin
          widx = word_index(req.addr);
          if (req.we) begin
            model_mem[widx] = merge_bytes(model_mem.exists(widx) ? model_mem[widx] : '0,
                                          req.wdata, req.be);
          end else if (model_mem.exists(widx)) begin
            nxt.rsp.rdata = model_mem[widx];
          end else begin
            fails[cur_tid]++;
            $display("%s: read of word %0d that was never written", test_name(cur_tid), widx);
          end
        end else begin
          nxt.rsp.error = 1'b1;   // Outside or unpowered
        end
      end
      exp_q.push_back(nxt);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_req(input logic we, input logic [31:0] addr, input logic [31:0] data,
                          input logic [NumBytes-1:0] be);
    ctn_req_t r;
    r.valid      = 1'b1;
    r.we         = we;
    r.addr       = addr;
    r.wdata.word = data;
    r.be         = be;
    @(posedge clk_aon);
    req <= r;
  endtask

  task automatic idle_cycle();
    @(posedge clk_aon);
    req <= '0;
  endtask

  task automatic drain_responses();
    repeat (RamLatency + 1) idle_cycle();
  endtask

  task automatic report_test(int id);
    $display("test %0s done: %0d checks, %0d failed", test_name(id), checks[id], fails[id]);
  endtask

  // Timed against the supply pattern so the first request lands on cycle 2
  task automatic reject_before_pok();
    logic [31:0] a;
    a = RamBase + 32'h40;
    cur_tid = 3'd1;
    send_req(1'b1, a, 32'hDEAD_BEEF, 4'hF);
    send_req(1'b0, a, 32'h0, 4'hF);
    send_req(1'b1, a + 32'h4, 32'h0BAD_0BAD, 4'h3);
    repeat (2) idle_cycle();
    send_req(1'b1, a, 32'h1234_5678, 4'hF);   // Cycle 7 in the first good window
    repeat (3) idle_cycle();
    send_req(1'b1, a, 32'hFFFF_0000, 4'hF);   // Cycle 11 during the dropout
    send_req(1'b0, a, 32'h0, 4'hF);
    repeat (3) idle_cycle();
    send_req(1'b0, a, 32'h0, 4'hF);           // Stable supply now
    drain_responses();
    report_test(1);
  endtask

  task automatic write_then_read();
    logic [31:0] a;
    cur_tid = 3'd2;
    for (int w = 0; w < FillWords; w++) begin
      a = RamBase + 32'(w * 4);
      send_req(1'b1, a, fill_value(a), 4'hF);
    end
    for (int w = 0; w < FillWords; w++) begin
      send_req(1'b0, RamBase + 32'(w * 4), 32'h0, 4'hF);
    end
    send_req(1'b1, RamBase + 32'h190, 32'hCAFE_F00D, 4'hF);   // Back to back on one word
    send_req(1'b0, RamBase + 32'h190, 32'h0, 4'hF);
    drain_responses();
    report_test(2);
  endtask

  task automatic partial_writes();
    logic [NumBytes-1:0] be_set [8];
    be_set = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'h5, 4'hA};
    cur_tid = 3'd3;
    for (int w = 0; w < 8; w++) begin
      send_req(1'b1, RamBase + 32'(w * 4), $urandom, be_set[w]);
    end
    send_req(1'b1, RamBase + 32'h20, 32'hFFFF_FFFF, 4'h0);   // No lanes enabled
    for (int w = 0; w < 9; w++) begin
      send_req(1'b0, RamBase + 32'(w * 4), 32'h0, 4'hF);
    end
    drain_responses();
    report_test(3);
  endtask

  task automatic outside_window();
    logic [31:0] top;
    top = RamBase + 32'(4 * (RamDepth - 1));
    cur_tid = 3'd4;
    send_req(1'b1, top, 32'h0BAD_F00D, 4'hF);
    send_req(1'b1, WinEnd, 32'hFFFF_FFFF, 4'hF);            // Aliases word 0
    send_req(1'b1, RamBase - 32'h4, 32'hFFFF_FFFF, 4'hF);   // Aliases the top word
    send_req(1'b0, WinEnd + 32'h4, 32'h0, 4'hF);
    send_req(1'b0, 32'h0, 32'h0, 4'hF);
    send_req(1'b0, RamBase, 32'h0, 4'hF);
    send_req(1'b0, top, 32'h0, 4'hF);
    drain_responses();
    report_test(4);
  endtask

  task automatic random_stream();
    int          kind;
    logic        we;
    logic [31:0] addr;
    cur_tid = 3'd5;
    for (int n = 0; n < NumRandom; n++) begin
      we = 1'($urandom_range(0, 1));
      if ($urandom_range(0, 99) < 80) begin
        addr = RamBase + 32'($urandom_range(0, FillWords - 1) * 4) + $urandom_range(0, 3);
      end else begin
        kind = $urandom_range(0, 2);
        case (kind)
          0:       addr = WinEnd + 32'($urandom_range(0, 255) * 4);
          1:       addr = RamBase - 32'($urandom_range(1, 256) * 4);
          default: addr = $urandom | 32'h8000_0000;
        endcase
      end
      send_req(we, addr, $urandom, 4'($urandom_range(0, 15)));
    end
    drain_responses();
    report_test(5);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_blk
    int total_checks;
    int total_fails;
    req = '0;
    cur_tid = 3'd1;
    void'($urandom(88));
    wait (rst_n == 1'b1);
    reject_before_pok();
    write_then_read();
    partial_writes();
    outside_window();
    random_stream();
    report_test(0);   // Supply is watched over the whole run
    total_checks = 0;
    total_fails  = 0;
    for (int i = 0; i < NumTests; i++) begin
      total_checks += checks[i];
      total_fails  += fails[i];
    end
    $display("summary: %0d tests, %0d checks, %0d failed", NumTests, total_checks, total_fails);
    if (total_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog: tests did not finish within %0d ns", TimeoutNs);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* ctn_port.f */
rtl/ctn_bus_pkg.sv
rtl/ctn_map_pkg.sv
rtl/ctn_por_emu.sv
rtl/ctn_steer.sv
rtl/ctn_sram_adapter.sv
rtl/ctn_ram_1p.sv
rtl/ctn_port_top.sv
bench/tb_clk_gen.sv
bench/tb_ctn_port.sv

/* Makefile */
# Verilator build and run for the CTN memory port testbench

VERILATOR ?= verilator
TOP       ?= tb_ctn_port
FILELIST  ?= ctn_port.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_TEXT := NO ERRORS
SIM_EXE   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard rtl/*.sv bench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_EXE)
	./$(SIM_EXE) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
